/* filelist.f */
+incdir+.
mmu_pkg.sv
tlb_fill_if.sv
tlb.sv
ptw.sv
mmu_top.sv
mmu_sva.sv
tb_mmu.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_mmu
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) mmu_settings.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

/* tb_mmu.sv */
`timescale 1ns/100ps

module tb_mmu;
    import mmu_pkg::*;

    localparam int   NUM_TESTS  = 26;
    localparam int   WALK_LIMIT = 200;
    localparam ppn_t SATP       = 22'h00100;
    // Second level tables
    localparam ppn_t L0_PPN     = 22'h00101;
    localparam ppn_t L0B_PPN    = 22'h00102;
    // Leaf flags, bits D A G U X W R V
    localparam logic [7:0] F_PTR  = 8'h01;
    localparam logic [7:0] F_RWXAD = 8'hcf;
    localparam logic [7:0] F_RWAD = 8'hc7;
    localparam logic [7:0] F_RWA  = 8'h47;
    localparam logic [7:0] F_RA   = 8'h43;
    localparam logic [7:0] F_WA   = 8'h45;
    localparam logic [7:0] F_XA   = 8'h49;
    localparam logic [7:0] F_RAD  = 8'hc3;

    logic   clk;
    logic   rst_n;
    ppn_t   satp_ppn;
    logic   mxr;
    logic   flush;
    logic   ireq;
    vaddr_t ivaddr;
    logic   ihit;
    paddr_t ipaddr;
    logic   dreq;
    vaddr_t dvaddr;
    logic   is_store;
    logic   dhit;
    paddr_t dpaddr;
    logic   pte_error;
    logic   walk_busy;
    logic   mem_req;
    paddr_t mem_addr;
    pte_t   mem_rdata;
    logic   mem_rvalid;

    pte_t   pt_mem [paddr_t];
    integer seed = 32'h5b07_c967;
    int     errors = 0;
    int     checks = 0;

    // Values handed to the compare process
    string  cmp_name;
    logic   exp_fault;
    logic   act_fault;
    paddr_t exp_pa;
    paddr_t act_pa;
    int     exp_mode;
    logic   act_req_seen;
    logic   act_busy_seen;
    int     act_cycles;
    event   cmp_ev;

    mmu_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .satp_ppn_i   (satp_ppn),
        .mxr_i        (mxr),
        .flush_i      (flush),
        .ireq_i       (ireq),
        .ivaddr_i     (ivaddr),
        .ihit_o       (ihit),
        .ipaddr_o     (ipaddr),
        .dreq_i       (dreq),
        .dvaddr_i     (dvaddr),
        .is_store_i   (is_store),
        .dhit_o       (dhit),
        .dpaddr_o     (dpaddr),
        .pte_error_o  (pte_error),
        .walk_busy_o  (walk_busy),
        .mem_req_o    (mem_req),
        .mem_addr_o   (mem_addr),
        .mem_rdata_i  (mem_rdata),
        .mem_rvalid_i (mem_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic pte_t make_pte(input ppn_t ppn, input logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    function automatic paddr_t pte_addr(input ppn_t table_ppn, input logic [9:0] idx);
        return {table_ppn, idx, 2'b00};
    endfunction

    // Returns {fault, physical address}
    function automatic logic [34:0] ref_walk(input ppn_t satp, input pte_t tbl [paddr_t],
                                             input vaddr_t va, input bit iport,
                                             input bit store, input bit mxr_v);
        paddr_t a;
        pte_t   pte;
        ppn_t   ppn;
        a = {satp, va[31:22], 2'b00};
        for (int lvl = 1; lvl >= 0; lvl--) begin
            pte = tbl.exists(a) ? tbl[a] : '0;
            ppn = pte[31:10];
            if (!pte[PTE_V] || (pte[PTE_W] && !pte[PTE_R]))
                return {1'b1, 34'd0};
            if (pte[PTE_R] || pte[PTE_X]) begin
                if (!pte[PTE_A])
                    return {1'b1, 34'd0};
                if (iport && !pte[PTE_X])
                    return {1'b1, 34'd0};
                if (!iport && !(pte[PTE_R] || (pte[PTE_X] && mxr_v)))
                    return {1'b1, 34'd0};
                if (!iport && store && !(pte[PTE_W] && pte[PTE_D]))
                    return {1'b1, 34'd0};
                if (lvl == 1) begin
                    if (ppn[9:0] != 10'd0)
                        return {1'b1, 34'd0};
                    return {1'b0, ppn[21:10], va[21:0]};
                end
                return {1'b0, ppn, va[11:0]};
            end
            // Pointer in the last table
            if (lvl == 0)
                return {1'b1, 34'd0};
            a = {ppn, va[21:12], 2'b00};
        end
        return {1'b1, 34'd0};
    endfunction

    // Memory model, answers each request once after 1 to 4 cycles
    initial begin
        int delay;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        forever begin
            @(negedge clk);
            if (rst_n && mem_req) begin
                delay = 1 + int'($unsigned($random(seed)) % 4);
                repeat (delay - 1) @(negedge clk);
                mem_rdata  = pt_mem.exists(mem_addr) ? pt_mem[mem_addr] : '0;
                mem_rvalid = 1'b1;
                @(negedge clk);
                mem_rvalid = 1'b0;
                while (mem_req) @(negedge clk);
            end
        end
    end

    // Mode 1 wants a hit in the request cycle, mode 2 wants a walk
    initial begin
        forever begin
            @(cmp_ev);
            checks++;
            if (exp_fault !== act_fault) begin
                errors++;
                $display("FAIL %s: fault expected %0b actual %0b", cmp_name, exp_fault, act_fault);
            end else if (!exp_fault && (exp_pa !== act_pa)) begin
                errors++;
                $display("FAIL %s: paddr expected %h actual %h", cmp_name, exp_pa, act_pa);
            end
            if (exp_mode == 1 && (act_req_seen || act_cycles != 1)) begin
                errors++;
                $display("FAIL %s: latency expected 1 cycle, read 0 actual %0d cycles, read %0b",
                         cmp_name, act_cycles, act_req_seen);
            end
            if (exp_mode == 2 && !(act_req_seen && act_busy_seen)) begin
                errors++;
                $display("FAIL %s: walk expected 1 actual 0", cmp_name);
            end
        end
    end

    task automatic access(input string name, input bit iport, input vaddr_t va,
                          input bit store, input bit mxr_v, input int mode);
        logic [34:0] r;
        int          cycles;
        bit          done;
        bit          timed_out;
        logic        req_seen;
        logic        busy_seen;
        r         = ref_walk(SATP, pt_mem, va, iport, store, mxr_v);
        cycles    = 0;
        done      = 0;
        timed_out = 0;
        req_seen  = 1'b0;
        busy_seen = 1'b0;
        is_store  = store;
        mxr       = mxr_v;
        if (iport) begin
            ireq   = 1'b1;
            ivaddr = va;
        end else begin
            dreq   = 1'b1;
            dvaddr = va;
        end
        while (!done) begin
            @(negedge clk);
            cycles++;
            req_seen  = req_seen | mem_req;
            busy_seen = busy_seen | walk_busy;
            if ((iport && ihit) || (!iport && dhit)) begin
                act_fault = 1'b0;
                act_pa    = iport ? ipaddr : dpaddr;
                done      = 1;
            end else if (pte_error) begin
                act_fault = 1'b1;
                act_pa    = '0;
                done      = 1;
                if (ihit || dhit) begin
                    errors++;
                    $display("FAIL %s: hit with page fault expected 0 actual 1", name);
                end
            end else if (cycles >= WALK_LIMIT) begin
                errors++;
                $display("ERROR %s: no hit and no page fault within %0d cycles", name, cycles);
                timed_out = 1;
                done      = 1;
            end
        end
        ireq     = 1'b0;
        dreq     = 1'b0;
        is_store = 1'b0;
        if (!timed_out) begin
            cmp_name      = name;
            exp_fault     = r[34];
            exp_pa        = r[33:0];
            exp_mode      = mode;
            act_req_seen  = req_seen;
            act_busy_seen = busy_seen;
            act_cycles    = cycles;
            ->cmp_ev;
        end
        @(negedge clk);
        if (pte_error) begin
            errors++;
            $display("FAIL %s: pte_error_o after the pulse expected 0 actual 1", name);
        end
        mxr = 1'b0;
    endtask

    task automatic flush_tlbs();
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        @(negedge clk);
    endtask

    // Flushes while the first PTE read of a data walk is outstanding
    task automatic flush_mid_walk(input vaddr_t va);
        int cycles;
        cycles = 0;
        dreq   = 1'b1;
        dvaddr = va;
        while (!mem_req && cycles < WALK_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!mem_req) begin
            errors++;
            $display("ERROR flush_mid_walk: walker never issued a memory read");
        end
        flush = 1'b1;
        dreq  = 1'b0;
        @(negedge clk);
        flush  = 1'b0;
        cycles = 0;
        while (walk_busy && cycles < WALK_LIMIT) begin
            if (pte_error) begin
                errors++;
                $display("FAIL flush_mid_walk: pte_error_o expected 0 actual 1");
            end
            @(negedge clk);
            cycles++;
        end
        if (walk_busy) begin
            errors++;
            $display("ERROR flush_mid_walk: walker did not return to idle after flush");
        end
    endtask

    initial begin
        repeat (NUM_TESTS * 2000) @(posedge clk);
        $display("ERROR watchdog expired after %0d cycles", NUM_TESTS * 2000);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        rst_n    = 1'b0;
        satp_ppn = SATP;
        mxr      = 1'b0;
        flush    = 1'b0;
        ireq     = 1'b0;
        ivaddr   = '0;
        dreq     = 1'b0;
        dvaddr   = '0;
        is_store = 1'b0;

        // Root table
        pt_mem[pte_addr(SATP, 10'd1)] = make_pte(L0_PPN, F_PTR);
        pt_mem[pte_addr(SATP, 10'd2)] = make_pte(22'h00c00, F_RWXAD);
        pt_mem[pte_addr(SATP, 10'd3)] = make_pte(22'h00c05, F_RAD);
        pt_mem[pte_addr(SATP, 10'd4)] = make_pte(L0B_PPN, F_PTR);
        pt_mem[pte_addr(L0B_PPN, 10'd0)] = make_pte(22'h00103, F_PTR);
        // Second level, page 2 left invalid
        pt_mem[pte_addr(L0_PPN, 10'd0)] = make_pte(22'h02000, F_RWXAD);
        pt_mem[pte_addr(L0_PPN, 10'd1)] = make_pte(22'h02001, F_RWAD);
        pt_mem[pte_addr(L0_PPN, 10'd3)] = make_pte(22'h02003, F_WA);
        pt_mem[pte_addr(L0_PPN, 10'd4)] = make_pte(22'h02004, F_RA);
        pt_mem[pte_addr(L0_PPN, 10'd5)] = make_pte(22'h02005, F_RWA);
        pt_mem[pte_addr(L0_PPN, 10'd6)] = make_pte(22'h02006, F_XA);
        for (int i = 7; i < 11; i++) begin
            pt_mem[pte_addr(L0_PPN, 10'(i))] = make_pte(22'h02010 + 22'(i), F_RWAD);
        end

        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (ihit || dhit || walk_busy || mem_req || pte_error) begin
            errors++;
            $display("FAIL reset: ihit dhit busy req error expected 00000 actual %b%b%b%b%b",
                     ihit, dhit, walk_busy, mem_req, pte_error);
        end

        access("d_first_4k",    0, 32'h0040_0123, 0, 0, 2);
        access("i_first_4k",    1, 32'h0040_0abc, 0, 0, 2);
        access("d_page1",       0, 32'h0040_1ffc, 0, 0, 2);
        access("i_no_exec",     1, 32'h0040_4010, 0, 0, 0);
        access("d_superpage",   0, 32'h0087_6543, 0, 0, 2);
        access("i_superpage",   1, 32'h0080_0010, 0, 0, 2);
        access("d_misaligned",  0, 32'h00c0_0000, 0, 0, 0);
        access("d_invalid",     0, 32'h0040_2000, 0, 0, 0);
        access("d_w_no_r",      0, 32'h0040_3000, 0, 0, 0);
        access("d_store_clean", 0, 32'h0040_5008, 1, 0, 0);
        access("d_xonly_mxr0",  0, 32'h0040_6020, 0, 0, 0);
        access("d_xonly_mxr1",  0, 32'h0040_6020, 0, 1, 2);
        access("d_ptr_level0",  0, 32'h0100_0000, 0, 0, 0);
        access("d_repeat_hit",  0, 32'h0040_0456, 0, 0, 1);
        access("i_repeat_hit",  1, 32'h0040_0abc, 0, 0, 1);

        // Round-robin eviction from an empty data TLB
        flush_tlbs();
        access("d_fill_0",      0, 32'h0040_0000, 0, 0, 2);
        access("d_fill_1",      0, 32'h0040_1000, 0, 0, 2);
        access("d_fill_7",      0, 32'h0040_7000, 0, 0, 2);
        access("d_fill_8",      0, 32'h0040_8000, 0, 0, 2);
        access("d_hit_0",       0, 32'h0040_0010, 0, 0, 1);
        access("d_fill_9",      0, 32'h0040_9000, 0, 0, 2);
        access("d_hit_1",       0, 32'h0040_1010, 0, 0, 1);
        access("d_evicted_0",   0, 32'h0040_0020, 0, 0, 2);

        flush_mid_walk(32'h0040_a000);
        access("d_after_flush", 0, 32'h0040_a044, 0, 0, 2);

        @(negedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* mmu_sva.sv */
`timescale 1ns/100ps

module mmu_sva (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 flush_i,
    input logic                 mem_req_o,
    input mmu_pkg::paddr_t      mem_addr_o,
    input logic                 itlb_update,
    input logic                 dtlb_update,
    input logic                 pte_error_o,
    input mmu_pkg::ptw_state_e  state_q
);
    import mmu_pkg::*;

    logic fill;
    // Set by a flush and held until the walker is back in idle
    logic flushed_q;

    assign fill = itlb_update || dtlb_update;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flushed_q <= 1'b0;
        end else if (flush_i) begin
            flushed_q <= 1'b1;
        end else if (state_q == PTW_IDLE) begin
            flushed_q <= 1'b0;
        end
    end

    // Address held for as long as the request stays up
    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req_o && $past(mem_req_o)) |-> $stable(mem_addr_o))
        else $error("mem_addr_o changed while mem_req_o was held");

    a_fill_xor_error: assert property (@(posedge clk) disable iff (!rst_n)
        !(fill && pte_error_o))
        else $error("TLB fill and pte_error_o in the same cycle");

    a_no_fill_after_flush: assert property (@(posedge clk) disable iff (!rst_n)
        (flush_i || flushed_q) |-> !fill)
        else $error("TLB fill after a flush before the walker went idle");

endmodule

bind ptw mmu_sva u_sva (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush_i),
    .mem_req_o   (mem_req_o),
    .mem_addr_o  (mem_addr_o),
    .itlb_update (itlb_update),
    .dtlb_update (dtlb_update),
    .pte_error_o (pte_error_o),
    .state_q     (state_q)
);

/* mmu_top.sv */
`timescale 1ns/100ps
`include "mmu_settings.svh"

module mmu_top (
    input  logic            clk,
    input  logic            rst_n,
    input  mmu_pkg::ppn_t   satp_ppn_i,
    input  logic            mxr_i,
    input  logic            flush_i,
    input  logic            ireq_i,
    input  mmu_pkg::vaddr_t ivaddr_i,
    output logic            ihit_o,
    output mmu_pkg::paddr_t ipaddr_o,
    input  logic            dreq_i,
    input  mmu_pkg::vaddr_t dvaddr_i,
    input  logic            is_store_i,
    output logic            dhit_o,
    output mmu_pkg::paddr_t dpaddr_o,
    output logic            pte_error_o,
    output logic            walk_busy_o,
    output logic            mem_req_o,
    output mmu_pkg::paddr_t mem_addr_o,
    input  mmu_pkg::pte_t   mem_rdata_i,
    input  logic            mem_rvalid_i
);
    logic imiss;
    logic dmiss;

    tlb_fill_if ifill ();
    tlb_fill_if dfill ();

    tlb #(.ENTRIES(`MMU_TLB_ENTRIES)) u_itlb (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush_i (flush_i),
        .vaddr_i (ivaddr_i),
        .req_i   (ireq_i),
        .hit_o   (ihit_o),
        .paddr_o (ipaddr_o),
        .miss_o  (imiss),
        .fill    (ifill.dst)
    );

    tlb #(.ENTRIES(`MMU_TLB_ENTRIES)) u_dtlb (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush_i (flush_i),
        .vaddr_i (dvaddr_i),
        .req_i   (dreq_i),
        .hit_o   (dhit_o),
        .paddr_o (dpaddr_o),
        .miss_o  (dmiss),
        .fill    (dfill.dst)
    );

    ptw u_ptw (
        .clk          (clk),
        .rst_n        (rst_n),
        .satp_ppn_i   (satp_ppn_i),
        .mxr_i        (mxr_i),
        .flush_i      (flush_i),
        .is_store_i   (is_store_i),
        .imiss_i      (imiss),
        .dmiss_i      (dmiss),
        .ivaddr_i     (ivaddr_i),
        .dvaddr_i     (dvaddr_i),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_rdata_i  (mem_rdata_i),
        .mem_rvalid_i (mem_rvalid_i),
        .ifill        (ifill.src),
        .dfill        (dfill.src),
        .busy_o       (walk_busy_o),
        .pte_error_o  (pte_error_o)
    );

endmodule

/* ptw.sv */
`timescale 1ns/100ps

module ptw (
    input  logic            clk,
    input  logic            rst_n,
    input  mmu_pkg::ppn_t   satp_ppn_i,
    input  logic            mxr_i,
    input  logic            flush_i,
    input  logic            is_store_i,
    input  logic            imiss_i,
    input  logic            dmiss_i,
    input  mmu_pkg::vaddr_t ivaddr_i,
    input  mmu_pkg::vaddr_t dvaddr_i,
    output logic            mem_req_o,
    output mmu_pkg::paddr_t mem_addr_o,
    input  mmu_pkg::pte_t   mem_rdata_i,
    input  logic            mem_rvalid_i,
    tlb_fill_if.src         ifill,
    tlb_fill_if.src         dfill,
    output logic            busy_o,
    output logic            pte_error_o
);
    import mmu_pkg::*;

    ptw_state_e state_q, state_d;
    ptw_level_e level_q, level_d;
    paddr_t     addr_q, addr_d;
    vaddr_t     vaddr_q, vaddr_d;
    logic       req_q, req_d;
    logic       iwalk_q, iwalk_d;
    pte_t       rdata_q;
    logic       rvalid_q;
    logic       itlb_update;
    logic       dtlb_update;
    ppn_t       pte_ppn;
    logic       perm_fault;
    logic       align_fault;

    assign pte_ppn = rdata_q[PTE_PPN_MSB:PTE_PPN_LSB];

    // Instruction walks need X, data walks need R (or X under mxr) and W with D for stores
    assign perm_fault = !rdata_q[PTE_A] ||
                        (iwalk_q ? !rdata_q[PTE_X]
                                 : (!(rdata_q[PTE_R] || (rdata_q[PTE_X] && mxr_i)) ||
                                    (is_store_i && (!rdata_q[PTE_W] || !rdata_q[PTE_D]))));

    // A superpage must point at a 4 MiB aligned frame
    assign align_fault = (level_q == LEVEL_1) && (pte_ppn[9:0] != '0);

    always_comb begin
        state_d     = state_q;
        level_d     = level_q;
        addr_d      = addr_q;
        vaddr_d     = vaddr_q;
        req_d       = req_q;
        iwalk_d     = iwalk_q;
        itlb_update = 1'b0;
        dtlb_update = 1'b0;

        case (state_q)
            PTW_IDLE: begin
                level_d = LEVEL_1;
                req_d   = 1'b0;
                if (dmiss_i) begin
                    addr_d  = {satp_ppn_i, dvaddr_i[31:22], 2'b00};
                    vaddr_d = dvaddr_i;
                    iwalk_d = 1'b0;
                    req_d   = 1'b1;
                    state_d = PTW_READ_PTE;
                end else if (imiss_i) begin
                    addr_d  = {satp_ppn_i, ivaddr_i[31:22], 2'b00};
                    vaddr_d = ivaddr_i;
                    iwalk_d = 1'b1;
                    req_d   = 1'b1;
                    state_d = PTW_READ_PTE;
                end
            end

            PTW_READ_PTE: begin
                if (rvalid_q) begin
                    req_d = 1'b0;
                    if (!rdata_q[PTE_V] || (rdata_q[PTE_W] && !rdata_q[PTE_R])) begin
                        state_d = PTW_FAULT;
                    end else if (rdata_q[PTE_R] || rdata_q[PTE_X]) begin
                        // Leaf entry
                        if (perm_fault || align_fault) begin
                            state_d = PTW_FAULT;
                        end else begin
                            itlb_update = iwalk_q;
                            dtlb_update = !iwalk_q;
                            state_d     = PTW_IDLE;
                        end
                    end else if (level_q == LEVEL_1) begin
                        level_d = LEVEL_0;
                        addr_d  = {pte_ppn, vaddr_q[21:12], 2'b00};
                    end else begin
                        // Pointer found in the last table
                        state_d = PTW_FAULT;
                    end
                end else if (!req_q) begin
                    // Second level read opens once the first one has closed
                    req_d = 1'b1;
                end
            end

            PTW_FAULT: begin
                state_d = PTW_IDLE;
            end

            PTW_DRAIN: begin
                if (rvalid_q) begin
                    req_d   = 1'b0;
                    state_d = PTW_IDLE;
                end
            end

            default: begin
                state_d = PTW_IDLE;
            end
        endcase

        if (flush_i) begin
            itlb_update = 1'b0;
            dtlb_update = 1'b0;
            if (req_q && !rvalid_q) begin
                state_d = PTW_DRAIN;
                req_d   = 1'b1;
            end else begin
                state_d = PTW_IDLE;
                req_d   = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= PTW_IDLE;
            level_q  <= LEVEL_1;
            req_q    <= 1'b0;
            iwalk_q  <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            level_q  <= level_d;
            req_q    <= req_d;
            iwalk_q  <= iwalk_d;
            rvalid_q <= mem_rvalid_i;
        end
    end

    always_ff @(posedge clk) begin
        addr_q  <= addr_d;
        vaddr_q <= vaddr_d;
        rdata_q <= mem_rdata_i;
    end

    assign mem_req_o   = req_q;
    assign mem_addr_o  = addr_q;
    assign busy_o      = (state_q != PTW_IDLE);
    assign pte_error_o = (state_q == PTW_FAULT);

    // Both TLBs see the same entry, only the strobe differs
    assign ifill.update    = itlb_update;
    assign ifill.vpn       = vaddr_q[31:12];
    assign ifill.ppn       = pte_ppn;
    assign ifill.superpage = (level_q == LEVEL_1);

    assign dfill.update    = dtlb_update;
    assign dfill.vpn       = vaddr_q[31:12];
    assign dfill.ppn       = pte_ppn;
    assign dfill.superpage = (level_q == LEVEL_1);

endmodule

/* tlb.sv */
`timescale 1ns/100ps
`include "mmu_settings.svh"

module tlb #(
    parameter int ENTRIES = `MMU_TLB_ENTRIES
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush_i,
    input  mmu_pkg::vaddr_t vaddr_i,
    input  logic            req_i,
    output logic            hit_o,
    output mmu_pkg::paddr_t paddr_o,
    output logic            miss_o,
    tlb_fill_if.dst         fill
);
    import mmu_pkg::*;

    localparam int IDX_W = $clog2(ENTRIES);

    logic [ENTRIES-1:0] valid_q;
    logic [ENTRIES-1:0] super_q;
    vpn_t               vpn_q [ENTRIES];
    ppn_t               ppn_q [ENTRIES];
    logic [IDX_W-1:0]   ptr_q;
    logic [ENTRIES-1:0] match;
    vpn_t               req_vpn;
    paddr_t             paddr;

    assign req_vpn = vaddr_i[31:12];

    // Superpages compare only VPN[1]
    always_comb begin
        match = '0;
        paddr = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            match[i] = valid_q[i] && (vpn_q[i][19:10] == req_vpn[19:10]) &&
                       (super_q[i] || (vpn_q[i][9:0] == req_vpn[9:0]));
            if (match[i]) begin
                paddr = super_q[i] ? {ppn_q[i][21:10], vaddr_i[21:0]}
                                   : {ppn_q[i], vaddr_i[11:0]};
            end
        end
    end

    assign hit_o   = req_i && (|match);
    assign miss_o  = req_i && !(|match);
    assign paddr_o = paddr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            ptr_q   <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
            ptr_q   <= '0;
        end else if (fill.update) begin
            valid_q[ptr_q] <= 1'b1;
            ptr_q          <= ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill.update) begin
            vpn_q[ptr_q]   <= fill.vpn;
            ppn_q[ptr_q]   <= fill.ppn;
            super_q[ptr_q] <= fill.superpage;
        end
    end

endmodule

/* tlb_fill_if.sv */
`timescale 1ns/100ps

interface tlb_fill_if;
    import mmu_pkg::*;

    // Single cycle write strobe
    logic update;
    vpn_t vpn;
    ppn_t ppn;
    // High for a 4 MiB leaf
    logic superpage;

    modport src (
        output update,
        output vpn,
        output ppn,
        output superpage
    );

    modport dst (
        input update,
        input vpn,
        input ppn,
        input superpage
    );

endinterface

/* mmu_pkg.sv */
`include "mmu_settings.svh"

package mmu_pkg;

    typedef logic [`MMU_VALEN-1:0]             vaddr_t;
    typedef logic [`MMU_PALEN-1:0]             paddr_t;
    typedef logic [`MMU_VALEN-`MMU_PGOFF-1:0]  vpn_t;
    // Also used for the satp root page number
    typedef logic [`MMU_PALEN-`MMU_PGOFF-1:0]  ppn_t;
    typedef logic [`MMU_XLEN-1:0]              pte_t;

    // Sv32 PTE field positions
    localparam int PTE_V       = 0;
    localparam int PTE_R       = 1;
    localparam int PTE_W       = 2;
    localparam int PTE_X       = 3;
    localparam int PTE_U       = 4;
    localparam int PTE_G       = 5;
    localparam int PTE_A       = 6;
    localparam int PTE_D       = 7;
    localparam int PTE_PPN_LSB = 10;
    localparam int PTE_PPN_MSB = 31;

    typedef enum logic [1:0] {
        PTW_IDLE     = 2'd0,
        PTW_READ_PTE = 2'd1,
        PTW_FAULT    = 2'd2,
        // Waits for the answer to a read dropped by a flush
        PTW_DRAIN    = 2'd3
    } ptw_state_e;

    // LEVEL_1 is the root table with 4 MiB leaves
    typedef enum logic {
        LEVEL_0 = 1'b0,
        LEVEL_1 = 1'b1
    } ptw_level_e;

endpackage

/* mmu_settings.svh */
`ifndef MMU_SETTINGS_SVH
`define MMU_SETTINGS_SVH

// Width of one page table entry read
`define MMU_XLEN 32

// Sv32 virtual and physical address widths
`define MMU_VALEN 32
`define MMU_PALEN 34

// Page offset bits, 4 KiB pages
`define MMU_PGOFF 12

// Entries in each TLB, a power of two from 2 to 16
`define MMU_TLB_ENTRIES 4

`endif
